/* all.f */
+incdir+source
source/div_pkg.sv
source/div_if.sv
source/clz32.sv
source/div_core.sv
source/div_wb_front.sv
source/div_result_regs.sv
source/div_wb_top.sv
sim/tb_div.sv

/* sim/tb_div.sv */
`timescale 1ns/1ps
`default_nettype none
`include "div_config.svh"

module tb_div import div_pkg::*; ();
    localparam int PERIOD    = 100;
    localparam int NUM_TESTS = 28;  // division runs plus the register test

    logic                   clk;
    logic                   rst;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`DIV_ADDR_W-1:0] wb_adr;
    word_t                  wb_dat_i;
    word_t                  wb_dat_o;
    logic                   wb_ack;
    int                     error_count;
    int                     check_count;
    logic [31:0]            lfsr_state;

    div_wb_top i_dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    // one classic transfer, driven and sampled on falling edges
    task automatic bus_cycle(input logic we, input logic [`DIV_ADDR_W-1:0] adr,
                             input word_t wdata, output word_t rdata);
        int waited;
        rdata = '0;
        @(negedge clk);
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_i} = {1'b1, 1'b1, we, adr, wdata};
        @(negedge clk);
        waited = 1;
        while (!wb_ack && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (wb_ack) rdata = wb_dat_o;
        else begin
            $display("no ack within 10 cycles for the access at offset %h", adr);
            error_count++;
        end
        {wb_cyc, wb_stb, wb_we} = 3'b000;
    endtask

    task automatic wb_write(input logic [`DIV_ADDR_W-1:0] adr, input word_t data);
        word_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [`DIV_ADDR_W-1:0] adr, output word_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output word_t value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // expected {quotient, remainder}
    function automatic logic [63:0] model_div(input word_t a, input word_t b,
                                              input div_mode_e mode);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        if (b == 32'd0) return {32'hFFFF_FFFF, a};
        if (a == 32'd0) return 64'd0;
        if (mode == DIV_UNSIGNED) return {a / b, a % b};
        if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) return {32'h8000_0000, 32'd0};
        return {sa / sb, sa % sb};  // truncating, remainder follows the dividend
    endfunction

    // polls status, which must show busy or done on every read
    task automatic wait_done(input string name);
        word_t status;
        int    polls;
        status = '0;
        polls  = 0;
        while (!status[STAT_DONE] && polls < 40) begin
            wb_read(`DIV_REG_CTRL, status);
            polls++;
            if (!status[STAT_BUSY] && !status[STAT_DONE]) begin
                $display("Error %s status: expected busy or done, actual %h", name, status);
                error_count++;
            end
        end
        if (!status[STAT_DONE]) begin
            $display("%s: done never set after %0d status reads", name, polls);
            error_count++;
        end
    endtask

    task automatic div_run(input string test, input word_t a, input word_t b,
                           input div_mode_e mode);
        logic [63:0] expected;
        word_t       q;
        word_t       r;
        string       name;
        name     = $sformatf("%s %h/%h", test, a, b);
        expected = model_div(a, b, mode);
        wb_write(`DIV_REG_DIVIDEND, a);
        wb_write(`DIV_REG_DIVISOR, b);
        wb_write(`DIV_REG_CTRL, {31'd0, mode});
        wait_done(name);
        wb_read(`DIV_REG_QUOTIENT, q);
        wb_read(`DIV_REG_REMAINDER, r);
        check_word({name, " quotient"}, expected[63:32], q);
        check_word({name, " remainder"}, expected[31:0], r);
    endtask

    task automatic test_regs();
        word_t value;
        wb_read(`DIV_REG_CTRL, value);
        check_word("test_regs status", 32'd0, value);
        wb_write(`DIV_REG_DIVIDEND, 32'h1234_5678);
        wb_write(`DIV_REG_DIVISOR, 32'h9abc_def0);
        wb_read(`DIV_REG_DIVIDEND, value);
        check_word("test_regs dividend", 32'h1234_5678, value);
        wb_read(`DIV_REG_DIVISOR, value);
        check_word("test_regs divisor", 32'h9abc_def0, value);
        for (int off = 5; off < 8; off++) begin
            wb_read(5'(off * 4), value);
            check_word($sformatf("test_regs offset %h", off * 4), 32'd0, value);
        end
    endtask

    task automatic test_unsigned();
        word_t a;
        word_t b;
        div_run("test_unsigned", 32'd100, 32'd7, DIV_UNSIGNED);
        div_run("test_unsigned", 32'd5, 32'd9, DIV_UNSIGNED);  // divisor greater
        div_run("test_unsigned", 32'd12345, 32'd1, DIV_UNSIGNED);
        div_run("test_unsigned", 32'hFFFF_FFFF, 32'd3, DIV_UNSIGNED);
        div_run("test_unsigned", 32'h8000_0000, 32'h8000_0000, DIV_UNSIGNED);
        for (int i = 0; i < 8; i++) begin
            rand_bits(32, a);
            rand_bits(32, b);
            div_run("test_unsigned", a, b >> (4 * i), DIV_UNSIGNED);  // spread of widths
        end
    endtask

    task automatic test_signed();
        word_t a;
        word_t b;
        div_run("test_signed", 32'd100, 32'd7, DIV_SIGNED);
        div_run("test_signed", -32'd100, 32'd7, DIV_SIGNED);
        div_run("test_signed", 32'd100, -32'd7, DIV_SIGNED);
        div_run("test_signed", -32'd100, -32'd7, DIV_SIGNED);
        div_run("test_signed", 32'h8000_0000, 32'hFFFF_FFFF, DIV_SIGNED);
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, a);
            rand_bits(32, b);
            div_run("test_signed", a, {b[31], b[30:0] >> (6 * i)}, DIV_SIGNED);
        end
    endtask

    task automatic test_special();
        div_run("test_special", 32'd1234, 32'd0, DIV_UNSIGNED);
        div_run("test_special", -32'd5, 32'd0, DIV_SIGNED);
        div_run("test_special", 32'd0, 32'd7, DIV_UNSIGNED);
        div_run("test_special", 32'd0, -32'd7, DIV_SIGNED);
    endtask

    task automatic test_busy();
        logic [63:0] expected;
        word_t       value;
        expected = model_div(32'hFFFF_FFF0, 32'd3, DIV_UNSIGNED);
        wb_write(`DIV_REG_DIVIDEND, 32'hFFFF_FFF0);
        wb_write(`DIV_REG_DIVISOR, 32'd3);
        wb_write(`DIV_REG_CTRL, 32'd0);
        // long run, so these arrive while busy and are dropped
        wb_write(`DIV_REG_DIVIDEND, 32'd5);
        wb_write(`DIV_REG_DIVISOR, 32'd7);
        wb_write(`DIV_REG_CTRL, 32'd1);
        wait_done("test_busy");
        wb_read(`DIV_REG_QUOTIENT, value);
        check_word("test_busy quotient", expected[63:32], value);
        wb_read(`DIV_REG_REMAINDER, value);
        check_word("test_busy remainder", expected[31:0], value);
        wb_read(`DIV_REG_DIVIDEND, value);
        check_word("test_busy dividend", 32'hFFFF_FFF0, value);
        wb_read(`DIV_REG_DIVISOR, value);
        check_word("test_busy divisor", 32'd3, value);
    endtask

    initial begin
        {clk, rst, wb_cyc, wb_stb, wb_we} = 5'b01000;
        wb_adr      = '0;
        wb_dat_i    = '0;
        error_count = 0;
        check_count = 0;
        lfsr_state  = 32'h9e12;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_regs();  // first, while status still shows reset
        test_unsigned();
        test_signed();
        test_special();
        test_busy();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) $display("Simulation PASSED");
        else $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 60 * PERIOD);
        $display("timeout, tests still running after %0d ns", NUM_TESTS * 60 * PERIOD);
        $display("Simulation FAILED");
        $finish;
    end
endmodule

`default_nettype wire

/* source/clz32.sv */
`timescale 1ns/1ps
`default_nettype none

module clz32 (
    input  logic [31:0] value,
    output logic [4:0]  count
);
    logic [7:0] nib_zero;  // one flag per nibble
    logic [2:0] lead_nib;  // all-zero nibbles above the first set one
    logic [3:0] nib;
    logic [1:0] nib_clz;

    always_comb begin
        for (int n = 0; n < 8; n++) begin
            nib_zero[n] = (value[4*n +: 4] == 4'd0);
        end
    end

    // scan up from the bottom so the highest nonzero nibble wins
    always_comb begin
        lead_nib = 3'd7;  // zero word ends up at nibble 0
        for (int n = 0; n < 8; n++) begin
            if (!nib_zero[n]) lead_nib = 3'(7 - n);
        end
    end

    assign nib = value[{~lead_nib, 2'b00} +: 4];  // ~lead_nib is the nibble index

    always_comb begin
        casez (nib)
            4'b1???: nib_clz = 2'd0;
            4'b01??: nib_clz = 2'd1;
            4'b001?: nib_clz = 2'd2;
            default: nib_clz = 2'd3;  // also the zero word, giving 31
        endcase
    end

    assign count = {lead_nib, nib_clz};
endmodule

`default_nettype wire

/* source/div_config.svh */
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// wishbone byte address, five registers of one word each
`define DIV_ADDR_W 5

`define DIV_REG_DIVIDEND  5'h00
`define DIV_REG_DIVISOR   5'h04
`define DIV_REG_CTRL      5'h08  // write: bit 0 selects signed and starts, read: status
`define DIV_REG_QUOTIENT  5'h0C
`define DIV_REG_REMAINDER 5'h10

`endif

/* source/div_core.sv */
`timescale 1ns/1ps
`default_nettype none

module div_core import div_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    div_req_if.core req,
    div_rsp_if.core rsp
);
    logic       signed_op;
    logic       neg_dividend;
    logic       neg_divisor;
    logic       neg_quotient;
    logic       neg_remainder;
    word_t      abs_dividend;
    word_t      abs_divisor;
    logic [4:0] dividend_clz;
    logic [4:0] divisor_clz;
    logic [4:0] clz_delta;        // divisor minus dividend leading zeros
    logic       divisor_greater;
    logic       divisor_zero;
    logic       dividend_zero;
    logic       early_exit;

    logic       running;
    logic [3:0] iter_cnt;         // remaining radix-4 steps minus one
    logic       last_iter;
    word_t      shifted_divisor;
    word_t      quo_q;
    word_t      rem_q;

    logic [33:0] diff_2x;
    logic [33:0] try_1x;
    logic [33:0] diff_1x;
    logic [1:0]  q_bits;
    word_t       rem_next;

    function automatic word_t negate_if(word_t a, logic neg);
        return neg ? (~a + 32'd1) : a;
    endfunction

    assign signed_op     = (req.mode == DIV_SIGNED);
    assign neg_dividend  = signed_op & req.dividend[31];
    assign neg_divisor   = signed_op & req.divisor[31];
    assign neg_quotient  = neg_dividend ^ neg_divisor;
    assign neg_remainder = neg_dividend;  // truncating division

    assign abs_dividend = negate_if(req.dividend, neg_dividend);
    assign abs_divisor  = negate_if(req.divisor, neg_divisor);

    clz32 i_clz_dividend (.value(abs_dividend), .count(dividend_clz));
    clz32 i_clz_divisor  (.value(abs_divisor),  .count(divisor_clz));

    // only used when the divisor is not greater, so never negative
    assign clz_delta       = divisor_clz - dividend_clz;
    assign divisor_greater = (abs_divisor > abs_dividend);
    assign divisor_zero    = (req.divisor == 32'd0);
    assign dividend_zero   = (req.dividend == 32'd0);
    assign early_exit      = divisor_greater | divisor_zero | dividend_zero;

    // one step: try 2x, then 1x on whatever is left
    assign diff_2x  = {2'b00, rem_q} - {1'b0, shifted_divisor, 1'b0};
    assign try_1x   = diff_2x[33] ? {2'b00, rem_q} : diff_2x;
    assign diff_1x  = try_1x - {2'b00, shifted_divisor};
    assign q_bits   = {~diff_2x[33], ~diff_1x[33]};
    assign rem_next = diff_1x[33] ? try_1x[31:0] : diff_1x[31:0];

    assign last_iter = (iter_cnt == 4'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            running         <= 1'b0;
            iter_cnt        <= 4'd0;
            shifted_divisor <= '0;
            quo_q           <= '0;
            rem_q           <= '0;
            rsp.done        <= 1'b0;
        end else begin
            rsp.done <= (running & last_iter) | (req.start & early_exit);
            if (req.start) begin
                running  <= ~early_exit;
                iter_cnt <= clz_delta[4:1];
                // align to an even shift so each step retires two bits
                shifted_divisor <= abs_divisor << {clz_delta[4:1], 1'b0};
                quo_q <= '0;
                rem_q <= abs_dividend;  // also the early-exit remainder
            end else if (running) begin
                running         <= ~last_iter;
                iter_cnt        <= iter_cnt - 4'd1;
                shifted_divisor <= shifted_divisor >> 2;
                quo_q           <= {quo_q[29:0], q_bits};
                rem_q           <= rem_next;
            end
        end
    end

    assign rsp.busy = running;

    // operands are still stable here, so the sign fix can stay combinational
    always_comb begin
        if (divisor_zero) begin
            rsp.quotient  = '1;
            rsp.remainder = req.dividend;
        end else if (dividend_zero) begin
            rsp.quotient  = '0;
            rsp.remainder = '0;
        end else begin
            rsp.quotient  = negate_if(quo_q, neg_quotient);
            rsp.remainder = negate_if(rem_q, neg_remainder);
        end
    end
endmodule

`default_nettype wire

/* source/div_if.sv */
`timescale 1ns/1ps
`default_nettype none

// operands and start from the bus side to the divider
interface div_req_if import div_pkg::*; ();
    div_mode_e mode;
    word_t     dividend;
    word_t     divisor;
    logic      start;     // one cycle, operands held until done

    modport front (output mode, dividend, divisor, start);
    modport core  (input mode, dividend, divisor, start);
endinterface

// divider status and results, raw and held
interface div_rsp_if import div_pkg::*; ();
    logic  busy;
    logic  done;              // one cycle, results valid with it
    word_t quotient;
    word_t remainder;
    word_t held_quotient;
    word_t held_remainder;
    logic  done_flag;         // sticky copy of done

    modport core   (output busy, done, quotient, remainder);
    modport result (input done, quotient, remainder,
                    output held_quotient, held_remainder, done_flag);
    modport front  (input busy, done, held_quotient, held_remainder, done_flag);
endinterface

`default_nettype wire

/* source/div_pkg.sv */
`default_nettype none

package div_pkg;

    typedef logic [31:0] word_t;  // operands, results and bus data

    typedef enum logic {
        DIV_UNSIGNED = 1'b0,
        DIV_SIGNED   = 1'b1
    } div_mode_e;

    // bits of the status word read at the ctrl offset
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;  // sticky until the next start

endpackage

`default_nettype wire

/* source/div_result_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_regs import div_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    div_rsp_if.result rsp_in,
    input  logic      req_start
);
    word_t quotient_q;
    word_t remainder_q;
    logic  done_q;

    // raw core results only hold while operands are stable, so take a copy
    always_ff @(posedge clk) begin
        if (rst) begin
            quotient_q  <= '0;
            remainder_q <= '0;
        end else if (rsp_in.done) begin
            quotient_q  <= rsp_in.quotient;
            remainder_q <= rsp_in.remainder;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (rsp_in.done) begin
            done_q <= 1'b1;
        end else if (req_start) begin
            done_q <= 1'b0;  // cleared for the new run
        end
    end

    assign rsp_in.held_quotient  = quotient_q;
    assign rsp_in.held_remainder = remainder_q;
    assign rsp_in.done_flag      = done_q;
endmodule

`default_nettype wire

/* source/div_wb_front.sv */
`timescale 1ns/1ps
`default_nettype none
`include "div_config.svh"

module div_wb_front import div_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`DIV_ADDR_W-1:0] wb_adr,
    input  word_t                  wb_dat_i,
    output word_t                  wb_dat_o,
    output logic                   wb_ack,
    div_req_if.front               req,
    div_rsp_if.front               rsp
);
    logic [`DIV_ADDR_W-1:0] reg_off;  // word aligned, byte lanes ignored
    logic      wb_req;
    logic      accept;
    logic      unit_busy;
    logic      wr;
    word_t     status;
    word_t     rd_data;
    word_t     dividend_q;
    word_t     divisor_q;
    div_mode_e mode_q;
    logic      start_q;

    assign reg_off = {wb_adr[4:2], 2'b00};
    assign wb_req  = wb_cyc & wb_stb;
    assign accept  = wb_req & ~wb_ack;  // one transfer per request

    // busy until the result block has taken the results
    assign unit_busy = rsp.busy | rsp.done;
    assign wr        = accept & wb_we & ~unit_busy;

    always_comb begin
        status            = '0;
        status[STAT_BUSY] = unit_busy;
        status[STAT_DONE] = rsp.done_flag;
    end

    always_comb begin
        case (reg_off)
            `DIV_REG_DIVIDEND:  rd_data = dividend_q;
            `DIV_REG_DIVISOR:   rd_data = divisor_q;
            `DIV_REG_CTRL:      rd_data = status;
            `DIV_REG_QUOTIENT:  rd_data = rsp.held_quotient;
            `DIV_REG_REMAINDER: rd_data = rsp.held_remainder;
            default:            rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            wb_dat_o   <= '0;
            dividend_q <= '0;
            divisor_q  <= '0;
            mode_q     <= DIV_UNSIGNED;
            start_q    <= 1'b0;
        end else begin
            wb_ack  <= accept;
            start_q <= wr & (reg_off == `DIV_REG_CTRL);  // any ctrl write starts
            if (accept & ~wb_we) wb_dat_o <= rd_data;
            if (wr) begin
                case (reg_off)
                    `DIV_REG_DIVIDEND: dividend_q <= wb_dat_i;
                    `DIV_REG_DIVISOR:  divisor_q  <= wb_dat_i;
                    `DIV_REG_CTRL:     mode_q     <= div_mode_e'(wb_dat_i[0]);
                    default: ;  // result offsets are read only
                endcase
            end
        end
    end

    assign req.mode     = mode_q;
    assign req.dividend = dividend_q;
    assign req.divisor  = divisor_q;
    assign req.start    = start_q;
endmodule

`default_nettype wire

/* source/div_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "div_config.svh"

module div_wb_top import div_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`DIV_ADDR_W-1:0] wb_adr,
    input  word_t                  wb_dat_i,
    output word_t                  wb_dat_o,
    output logic                   wb_ack
);
    div_req_if req_if ();
    div_rsp_if rsp_if ();

    // bus side, owns the operand registers
    div_wb_front i_front (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .req      (req_if.front),
        .rsp      (rsp_if.front)
    );

    div_core i_core (
        .clk (clk),
        .rst (rst),
        .req (req_if.core),
        .rsp (rsp_if.core)
    );

    div_result_regs i_result (
        .clk       (clk),
        .rst       (rst),
        .rsp_in    (rsp_if.result),
        .req_start (req_if.start)  // clears the sticky done
    );
endmodule

`default_nettype wire
